// File: Makefile
VERILATOR  ?= verilator
TOP        ?= core_pipeline_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module core_pipeline src/isa_pkg.sv src/pipe_pkg.sv \
		src/fetch_stage.sv src/decode_stage.sv src/issue_stage.sv src/execute_stage.sv \
		src/core_pipeline.sv

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/issue_stage.sv
src/execute_stage.sv
src/core_pipeline.sv
tb/mem_model.sv
tb/core_pipeline_tb.sv

// File: src/core_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipeline import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    output logic      imem_req_valid,
    output imem_req_t imem_req,
    input  logic      imem_credit,
    input  logic      imem_rsp_valid,
    input  imem_rsp_t imem_rsp,
    output logic      dmem_req_valid,
    output dmem_req_t dmem_req,
    input  logic      dmem_credit,
    input  logic      dmem_rsp_valid,
    input  dmem_rsp_t dmem_rsp,
    output logic      busy,
    output logic      ebreak
);

    redirect_t redirect;
    wb_t       wb;
    logic      halted;
    logic      fetch_idle;
    logic      mem_idle;

    logic      f_valid;
    logic      f_ready;
    instr_t    f_instr;
    word_t     f_pc;
    logic      d_valid;
    logic      d_ready;
    decoded_t  d_uop;
    logic      i_valid;
    logic      i_ready;
    issue_t    i_item;

    fetch_stage i_fetch_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect       (redirect),
        .halt           (halted),
        .out_valid      (f_valid),
        .out_instr      (f_instr),
        .out_pc         (f_pc),
        .out_ready      (f_ready),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp       (imem_rsp),
        .fetch_idle     (fetch_idle)
    );

    decode_stage i_decode_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (redirect.valid),
        .in_valid  (f_valid),
        .in_instr  (f_instr),
        .in_pc     (f_pc),
        .in_ready  (f_ready),
        .out_valid (d_valid),
        .out_uop   (d_uop),
        .out_ready (d_ready)
    );

    issue_stage i_issue_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (redirect.valid),
        .in_valid  (d_valid),
        .in_uop    (d_uop),
        .in_ready  (d_ready),
        .out_valid (i_valid),
        .out_item  (i_item),
        .out_ready (i_ready),
        .wb        (wb)
    );

    execute_stage i_execute_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (i_valid),
        .in_item        (i_item),
        .in_ready       (i_ready),
        .wb             (wb),
        .redirect       (redirect),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_credit    (dmem_credit),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp       (dmem_rsp),
        .halted         (halted),
        .mem_idle       (mem_idle)
    );

    // Stays busy until halted and both memory ports are drained
    assign busy   = !halted || !fetch_idle || !mem_idle;
    assign ebreak = halted;

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  instr_t   in_instr,
    input  word_t    in_pc,
    output logic     in_ready,
    output logic     out_valid,
    output decoded_t out_uop,
    input  logic     out_ready
);

    decoded_t dec;

    always_comb begin
        dec           = '0;
        dec.opcode    = in_instr.opcode;
        dec.rd        = in_instr.rd;
        dec.rs1       = in_instr.rs1;
        dec.rs2       = in_instr.rs2;
        dec.imm       = {{16{in_instr.imm[15]}}, in_instr.imm};
        dec.pc        = in_pc[31:2];
        case (in_instr.opcode)
            OP_ADDI, OP_LW: begin
                dec.writes_rd = 1'b1;
                dec.uses_rs1  = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND: begin
                dec.writes_rd = 1'b1;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
            end
            OP_TID:    dec.writes_rd = 1'b1;
            OP_SW: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            OP_BEQZ:   dec.uses_rs1 = 1'b1;
            OP_EBREAK: dec.opcode   = OP_EBREAK;
            default:   dec.opcode   = OP_EBREAK;
        endcase
        // Writes to r0 are discarded here so the scoreboard never tracks r0
        if (dec.rd == '0) begin
            dec.writes_rd = 1'b0;
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_uop <= dec;
        end
    end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  issue_t    in_item,
    output logic      in_ready,
    output wb_t       wb,
    output redirect_t redirect,
    output logic      dmem_req_valid,
    output dmem_req_t dmem_req,
    input  logic      dmem_credit,
    input  logic      dmem_rsp_valid,
    input  dmem_rsp_t dmem_rsp,
    output logic      halted,
    output logic      mem_idle
);

    logic               ex_valid;
    issue_t             ex;
    opcode_e            op;
    logic [DCRED_W-1:0] credits;
    logic               ld_pending;
    logic               ld_tag;
    logic               req_tag;
    logic               req_fire;
    logic               ex_done;
    logic               taken;
    lane_words_t        alu_res;
    lane_words_t        eff_addr;

    assign op = ex.uop.opcode;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            eff_addr[l] = ex.rs1_val[l] + ex.uop.imm;
            case (op)
                OP_ADDI: alu_res[l] = eff_addr[l];
                OP_ADD:  alu_res[l] = ex.rs1_val[l] + ex.rs2_val[l];
                OP_SUB:  alu_res[l] = ex.rs1_val[l] - ex.rs2_val[l];
                OP_AND:  alu_res[l] = ex.rs1_val[l] & ex.rs2_val[l];
                OP_TID:  alu_res[l] = word_t'(l);
                OP_LW:   alu_res[l] = dmem_rsp.data[l];
                default: alu_res[l] = '0;
            endcase
        end
    end

    // One load in flight at most, and the stage waits for it
    assign req_fire = ex_valid && (op == OP_LW || op == OP_SW) && !ld_pending
                   && credits != '0;

    always_comb begin
        dmem_req.rw  = op == OP_SW;
        dmem_req.tag = req_tag;
        dmem_req.data = ex.rs2_val;
        for (int l = 0; l < NUM_LANES; l++) begin
            dmem_req.byteen[l] = 4'hf;
            dmem_req.addr[l]   = eff_addr[l][31:2];
        end
    end
    assign dmem_req_valid = req_fire;

    always_comb begin
        case (op)
            OP_SW:   ex_done = ex_valid && req_fire;
            OP_LW:   ex_done = ex_valid && ld_pending && dmem_rsp_valid;
            default: ex_done = ex_valid;
        endcase
    end

    // Branch looks at lane 0 only
    assign taken        = ex_valid && op == OP_BEQZ && ex.rs1_val[0] == '0;
    assign redirect.valid = taken;
    assign redirect.pc  = {ex.uop.pc, 2'b00} + {ex.uop.imm[29:0], 2'b00};

    assign wb.valid = ex_done && ex.uop.writes_rd;
    assign wb.rd    = ex.uop.rd;
    assign wb.data  = alu_res;

    assign in_ready = !halted && (!ex_valid || (ex_done && !taken && op != OP_EBREAK));
    assign mem_idle = credits == DCRED_W'(DMEM_CREDITS) && !ld_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid   <= 1'b0;
            credits    <= DCRED_W'(DMEM_CREDITS);
            ld_pending <= 1'b0;
            ld_tag     <= 1'b0;
            req_tag    <= 1'b0;
            halted     <= 1'b0;
        end else begin
            credits <= credits - DCRED_W'(req_fire) + DCRED_W'(dmem_credit);
            if (in_valid && in_ready) begin
                ex_valid <= 1'b1;
            end else if (ex_done) begin
                ex_valid <= 1'b0;
            end
            if (req_fire) begin
                req_tag <= ~req_tag;
            end
            if (req_fire && op == OP_LW) begin
                ld_pending <= 1'b1;
                ld_tag     <= req_tag;
            end else if (dmem_rsp_valid) begin
                ld_pending <= 1'b0;
            end
            if (ex_valid && op == OP_EBREAK) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ex <= in_item;
        end
    end

    a_rsp_for_load: assert property (
        @(posedge clk) disable iff (!arst_n)
        dmem_rsp_valid |-> ld_pending && dmem_rsp.tag == ld_tag
    );

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  redirect_t redirect,
    input  logic      halt,
    output logic      out_valid,
    output instr_t    out_instr,
    output word_t     out_pc,
    input  logic      out_ready,
    output logic      imem_req_valid,
    output imem_req_t imem_req,
    input  logic      imem_credit,
    input  logic      imem_rsp_valid,
    input  imem_rsp_t imem_rsp,
    output logic      fetch_idle
);

    word_t               pc_q;
    word_t               head_pc;
    logic [ICRED_W-1:0]  credits;
    logic [ICRED_W-1:0]  count;
    logic [SLOT_W-1:0]   head;
    logic [SLOT_W-1:0]   tail;
    logic                epoch;
    logic                started;
    logic [IMEM_CREDITS-1:0] full;
    instr_t              slot_instr [IMEM_CREDITS];
    logic                req_fire;
    logic                out_fire;
    logic                rsp_hit;
    logic [SLOT_W-1:0]   rsp_slot;

    assign req_fire = started && !halt && credits != '0 && count < ICRED_W'(IMEM_CREDITS);
    assign imem_req_valid = req_fire;
    assign imem_req = '{addr: pc_q[31:2], tag: {epoch, tail}};

    // Responses from before the last redirect are dropped
    assign rsp_slot = imem_rsp.tag[SLOT_W-1:0];
    assign rsp_hit  = imem_rsp_valid && imem_rsp.tag[ITAG_W-1] == epoch;

    // Slots drain strictly in request order
    assign out_valid = full[head];
    assign out_instr = slot_instr[head];
    assign out_pc    = head_pc;
    assign out_fire  = out_valid && out_ready;

    assign fetch_idle = credits == ICRED_W'(IMEM_CREDITS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
            pc_q    <= '0;
            head_pc <= '0;
            credits <= ICRED_W'(IMEM_CREDITS);
            count   <= '0;
            head    <= '0;
            tail    <= '0;
            epoch   <= 1'b0;
            full    <= '0;
        end else begin
            started <= 1'b1;
            credits <= credits - ICRED_W'(req_fire) + ICRED_W'(imem_credit);
            if (redirect.valid) begin
                pc_q    <= redirect.pc;
                head_pc <= redirect.pc;
                count   <= '0;
                head    <= '0;
                tail    <= '0;
                epoch   <= ~epoch;
                full    <= '0;
            end else begin
                if (req_fire) begin
                    pc_q <= pc_q + 32'd4;
                    tail <= tail + 1'b1;
                end
                if (out_fire) begin
                    head       <= head + 1'b1;
                    head_pc    <= head_pc + 32'd4;
                    full[head] <= 1'b0;
                end
                if (rsp_hit) begin
                    full[rsp_slot] <= 1'b1;
                end
                count <= count + ICRED_W'(req_fire) - ICRED_W'(out_fire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            slot_instr[rsp_slot] <= instr_t'(imem_rsp.data);
        end
    end

    a_credits_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
        credits <= ICRED_W'(IMEM_CREDITS)
    );

endmodule

`default_nettype wire

// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int NUM_REGS = 8;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADDI   = 4'h0,
        OP_ADD    = 4'h1,
        OP_SUB    = 4'h2,
        OP_AND    = 4'h3,
        OP_TID    = 4'h4,
        OP_LW     = 4'h5,
        OP_SW     = 4'h6,
        OP_BEQZ   = 4'h7,
        OP_EBREAK = 4'h8
    } opcode_e;

    // Opcode in the top nibble, immediate in the low half
    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  rsvd;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [31:0] imm;
        logic        writes_rd;
        logic        uses_rs1;
        logic        uses_rs2;
        // Word address
        logic [29:0] pc;
    } decoded_t;

endpackage

`default_nettype wire

// File: src/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  decoded_t in_uop,
    output logic     in_ready,
    output logic     out_valid,
    output issue_t   out_item,
    input  logic     out_ready,
    input  wb_t      wb
);

    lane_words_t         rf [NUM_REGS];
    logic [NUM_REGS-1:0] pending;
    logic                item_valid;
    decoded_t            item;
    logic                hazard;
    logic                out_fire;

    // No forwarding, so any pending source or destination holds the item
    assign hazard = (item.uses_rs1 && pending[item.rs1])
                 || (item.uses_rs2 && pending[item.rs2])
                 || (item.writes_rd && pending[item.rd]);

    assign out_valid = item_valid && !hazard;
    assign out_fire  = out_valid && out_ready;
    assign in_ready  = !item_valid || out_fire;

    assign out_item.uop     = item;
    assign out_item.rs1_val = (item.rs1 == '0) ? '0 : rf[item.rs1];
    assign out_item.rs2_val = (item.rs2 == '0) ? '0 : rf[item.rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            item_valid <= 1'b0;
        end else if (flush) begin
            item_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            item_valid <= 1'b1;
        end else if (out_fire) begin
            item_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (wb.valid) begin
                pending[wb.rd] <= 1'b0;
            end
            if (out_fire && !flush && item.writes_rd) begin
                pending[item.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready && !flush) begin
            item <= in_uop;
        end
        if (wb.valid) begin
            rf[wb.rd] <= wb.data;
        end
    end

    a_wb_was_pending: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid |-> pending[wb.rd]
    );

endmodule

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    localparam int NUM_LANES    = 4;
    localparam int IMEM_CREDITS = 4;
    localparam int DMEM_CREDITS = 2;
    localparam int ITAG_W       = 3;
    localparam int SLOT_W       = ITAG_W - 1;
    localparam int ICRED_W      = $clog2(IMEM_CREDITS + 1);
    localparam int DCRED_W      = $clog2(DMEM_CREDITS + 1);

    typedef logic [31:0] word_t;
    typedef word_t [NUM_LANES-1:0] lane_words_t;

    // Tag is {epoch, queue slot}
    typedef struct packed {
        logic [29:0]       addr;
        logic [ITAG_W-1:0] tag;
    } imem_req_t;

    typedef struct packed {
        word_t             data;
        logic [ITAG_W-1:0] tag;
    } imem_rsp_t;

    typedef struct packed {
        logic                         rw;
        logic [NUM_LANES-1:0][3:0]    byteen;
        logic [NUM_LANES-1:0][29:0]   addr;
        lane_words_t                  data;
        logic                         tag;
    } dmem_req_t;

    typedef struct packed {
        lane_words_t data;
        logic        tag;
    } dmem_rsp_t;

    typedef struct packed {
        decoded_t    uop;
        lane_words_t rs1_val;
        lane_words_t rs2_val;
    } issue_t;

    typedef struct packed {
        logic        valid;
        reg_idx_t    rd;
        lane_words_t data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: tb/core_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipeline_tb import isa_pkg::*, pipe_pkg::*; ();

    // Program lengths in instructions, in test order
    localparam int TOTAL_INSTR = 8 + 6 + 8 + 9 + 8 + 4;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_INSTR;
    localparam int HOLD_CYCLES = 40;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      hold_credits;
    logic      imem_req_valid;
    imem_req_t imem_req;
    logic      imem_credit;
    logic      imem_rsp_valid;
    imem_rsp_t imem_rsp;
    logic      dmem_req_valid;
    dmem_req_t dmem_req;
    logic      dmem_credit;
    logic      dmem_rsp_valid;
    dmem_rsp_t dmem_rsp;
    logic      busy;
    logic      ebreak;

    dmem_req_t stores [$];
    word_t     prog [$];
    int        icred;
    int        dcred;

    always #10 clk = ~clk;

    core_pipeline i_core_pipeline (
        .clk            (clk),
        .arst_n         (arst_n),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp       (imem_rsp),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_credit    (dmem_credit),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp       (dmem_rsp),
        .busy           (busy),
        .ebreak         (ebreak)
    );

    mem_model i_mem_model (
        .clk            (clk),
        .arst_n         (arst_n),
        .hold_credits   (hold_credits),
        .imem_req_valid (imem_req_valid),
        .imem_req       (imem_req),
        .imem_credit    (imem_credit),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp       (imem_rsp),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_credit    (dmem_credit),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp       (dmem_rsp)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Request monitor with its own credit bookkeeping
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            icred = IMEM_CREDITS;
            dcred = DMEM_CREDITS;
        end else begin
            if (imem_req_valid && icred == 0) begin
                fail_now("Instruction request sent with no credit left");
            end
            if (dmem_req_valid && dcred == 0) begin
                fail_now("Data request sent with no credit left");
            end
            if (ebreak && !busy && (imem_req_valid || dmem_req_valid)) begin
                fail_now("Memory request seen after the core went idle");
            end
            icred = icred - int'(imem_req_valid) + int'(imem_credit);
            dcred = dcred - int'(dmem_req_valid) + int'(dmem_credit);
            if (dmem_req_valid && dmem_req.rw) begin
                stores.push_back(dmem_req);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now("Watchdog expired before all tests finished");
    end

    function automatic word_t enc(input opcode_e op, input int rd, input int rs1,
                                  input int rs2, input int imm);
        instr_t i;
        i.opcode = op;
        i.rd     = reg_idx_t'(rd);
        i.rs1    = reg_idx_t'(rs1);
        i.rs2    = reg_idx_t'(rs2);
        i.rsvd   = '0;
        i.imm    = imm[15:0];
        return word_t'(i);
    endfunction

    // Byte addresses in, word addresses out
    function automatic dmem_req_t make_store(input lane_words_t byte_addr,
                                             input lane_words_t data, input logic tag);
        dmem_req_t r;
        r.rw   = 1'b1;
        r.data = data;
        r.tag  = tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            r.byteen[l] = 4'hf;
            r.addr[l]   = byte_addr[l][31:2];
        end
        return r;
    endfunction

    task automatic check_store(input int idx, input dmem_req_t exp);
        if (idx >= stores.size()) begin
            fail_now($sformatf("Store %0d never appeared", idx));
        end
        if (stores[idx] !== exp) begin
            fail_now($sformatf("Error: dmem_req store %0d exp %h got %h",
                               idx, exp, stores[idx]));
        end
    endtask

    task automatic check_store_count(input int exp);
        if (stores.size() != exp) begin
            fail_now($sformatf("Error: store count exp %h got %h", exp, stores.size()));
        end
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_ebreak);
        if ({busy, ebreak} !== {exp_busy, exp_ebreak}) begin
            fail_now($sformatf("Error: busy,ebreak exp %h got %h",
                               {exp_busy, exp_ebreak}, {busy, ebreak}));
        end
    endtask

    task automatic run_program(input int hold_cycles);
        @(posedge clk);
        arst_n       <= 1'b0;
        hold_credits <= hold_cycles > 0;
        for (int a = 0; a < prog.size(); a++) begin
            i_mem_model.write_instr(30'(a), prog[a]);
        end
        repeat (10) @(posedge clk);
        stores.delete();
        arst_n <= 1'b1;
        if (hold_cycles > 0) begin
            repeat (hold_cycles) @(posedge clk);
            if (icred != 0) begin
                fail_now("Instruction credits were not used up while held");
            end
            hold_credits <= 1'b0;
        end
        do @(negedge clk); while (!ebreak);
        do @(negedge clk); while (busy);
        check_status(1'b0, 1'b1);
    endtask

    task automatic alu_program();
        prog = '{enc(OP_ADDI, 1, 0, 0, 100), enc(OP_ADDI, 2, 0, 0, -7),
                 enc(OP_ADD, 3, 1, 2, 0), enc(OP_SUB, 4, 3, 2, 0),
                 enc(OP_AND, 5, 4, 3, 0), enc(OP_ADDI, 6, 0, 0, 64),
                 enc(OP_SW, 0, 6, 5, 8), enc(OP_EBREAK, 0, 0, 0, 0)};
    endtask

    task automatic check_alu_store();
        word_t       a;
        word_t       b;
        word_t       c;
        word_t       d;
        lane_words_t addr;
        lane_words_t data;
        a = 32'd100;
        b = -32'sd7;
        c = a + b;
        d = c - b;
        for (int l = 0; l < NUM_LANES; l++) begin
            addr[l] = 32'd72;
            data[l] = d & c;
        end
        check_store_count(1);
        check_store(0, make_store(addr, data, 1'b0));
    endtask

    task automatic test_alu();
        i_mem_model.clear_mem();
        alu_program();
        run_program(0);
        check_alu_store();
    endtask

    task automatic test_lanes();
        lane_words_t addr;
        lane_words_t data;
        i_mem_model.clear_mem();
        prog = '{enc(OP_TID, 1, 0, 0, 0), enc(OP_ADDI, 2, 1, 0, 10),
                 enc(OP_ADD, 4, 1, 1, 0), enc(OP_ADD, 4, 4, 4, 0),
                 enc(OP_SW, 0, 4, 2, 32), enc(OP_EBREAK, 0, 0, 0, 0)};
        run_program(0);
        for (int l = 0; l < NUM_LANES; l++) begin
            addr[l] = word_t'(4 * l + 32);
            data[l] = word_t'(l + 10);
        end
        check_store_count(1);
        check_store(0, make_store(addr, data, 1'b0));
    endtask

    task automatic test_load_use();
        lane_words_t pre;
        lane_words_t addr;
        lane_words_t data;
        prog = '{enc(OP_TID, 1, 0, 0, 0), enc(OP_ADD, 2, 1, 1, 0),
                 enc(OP_ADD, 2, 2, 2, 0), enc(OP_LW, 3, 2, 0, 256),
                 enc(OP_ADDI, 4, 0, 0, 5), enc(OP_ADD, 5, 3, 4, 0),
                 enc(OP_SW, 0, 2, 5, 512), enc(OP_EBREAK, 0, 0, 0, 0)};
        for (int l = 0; l < NUM_LANES; l++) begin
            pre[l]  = 32'h1000_0000 + word_t'(17 * l);
            addr[l] = word_t'(512 + 4 * l);
            data[l] = pre[l] + 32'd5;
        end
        i_mem_model.clear_mem();
        for (int l = 0; l < NUM_LANES; l++) begin
            i_mem_model.write_data(30'(64 + l), pre[l]);
        end
        run_program(0);
        check_store_count(1);
        check_store(0, make_store(addr, data, 1'b1));
    endtask

    task automatic test_branch();
        lane_words_t addr;
        lane_words_t data;
        i_mem_model.clear_mem();
        // Taken branch from index 1 lands on index 4
        prog = '{enc(OP_ADDI, 1, 0, 0, 3), enc(OP_BEQZ, 0, 0, 0, 3),
                 enc(OP_SW, 0, 0, 1, 0), enc(OP_SW, 0, 0, 1, 4),
                 enc(OP_SW, 0, 0, 1, 8), enc(OP_BEQZ, 0, 1, 0, 2),
                 enc(OP_ADDI, 2, 0, 0, 9), enc(OP_SW, 0, 0, 2, 12),
                 enc(OP_EBREAK, 0, 0, 0, 0)};
        run_program(0);
        check_store_count(2);
        for (int l = 0; l < NUM_LANES; l++) begin
            addr[l] = 32'd8;
            data[l] = 32'd3;
        end
        check_store(0, make_store(addr, data, 1'b0));
        for (int l = 0; l < NUM_LANES; l++) begin
            addr[l] = 32'd12;
            data[l] = 32'd9;
        end
        check_store(1, make_store(addr, data, 1'b1));
    endtask

    task automatic test_backpressure();
        i_mem_model.clear_mem();
        alu_program();
        run_program(HOLD_CYCLES);
        check_alu_store();
    endtask

    task automatic test_halt();
        i_mem_model.clear_mem();
        prog = '{enc(OP_ADDI, 1, 0, 0, 1), enc(OP_EBREAK, 0, 0, 0, 0),
                 enc(OP_SW, 0, 0, 1, 0), enc(OP_SW, 0, 0, 1, 4)};
        run_program(0);
        repeat (50) begin
            @(negedge clk);
            check_status(1'b0, 1'b1);
        end
        check_store_count(0);
    endtask

    initial begin
        arst_n       = 1'b0;
        hold_credits = 1'b0;
        test_alu();
        test_lanes();
        test_load_use();
        test_branch();
        test_backpressure();
        test_halt();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      hold_credits,
    input  logic      imem_req_valid,
    input  imem_req_t imem_req,
    output logic      imem_credit,
    output logic      imem_rsp_valid,
    output imem_rsp_t imem_rsp,
    input  logic      dmem_req_valid,
    input  dmem_req_t dmem_req,
    output logic      dmem_credit,
    output logic      dmem_rsp_valid,
    output dmem_rsp_t dmem_rsp
);

    word_t     imem [logic [29:0]];
    word_t     dmem [logic [29:0]];
    imem_rsp_t irsp_q [$];
    int        irsp_due [$];
    dmem_rsp_t drsp_q [$];
    int        drsp_due [$];
    int        icred_due [$];
    int        dcred_due [$];
    int        cycle;
    int        seed = 13651;
    int        idx;
    dmem_rsp_t rd_rsp;

    // Unwritten instruction words halt the core
    function automatic word_t read_instr(input logic [29:0] addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return {OP_EBREAK, 28'h0};
    endfunction

    function automatic word_t read_data(input logic [29:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return {addr, 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic int rand_delay();
        return 1 + int'($unsigned($random(seed)) % 4);
    endfunction

    // Index of the oldest entry whose time has come, or -1
    function automatic int first_due(input int due[$], input int now);
        for (int i = 0; i < due.size(); i++) begin
            if (due[i] <= now) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic clear_mem();
        imem.delete();
        dmem.delete();
    endtask

    task automatic write_instr(input logic [29:0] addr, input word_t value);
        imem[addr] = value;
    endtask

    task automatic write_data(input logic [29:0] addr, input word_t value);
        dmem[addr] = value;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irsp_q.delete();
            irsp_due.delete();
            drsp_q.delete();
            drsp_due.delete();
            icred_due.delete();
            dcred_due.delete();
            cycle          = 0;
            imem_credit    <= 1'b0;
            imem_rsp_valid <= 1'b0;
            imem_rsp       <= '0;
            dmem_credit    <= 1'b0;
            dmem_rsp_valid <= 1'b0;
            dmem_rsp       <= '0;
        end else begin
            cycle = cycle + 1;
            imem_credit    <= 1'b0;
            imem_rsp_valid <= 1'b0;
            dmem_credit    <= 1'b0;
            dmem_rsp_valid <= 1'b0;
            if (imem_req_valid) begin
                irsp_q.push_back(imem_rsp_t'{data: read_instr(imem_req.addr),
                                             tag: imem_req.tag});
                irsp_due.push_back(cycle + rand_delay());
                icred_due.push_back(cycle + rand_delay());
            end
            if (dmem_req_valid) begin
                if (dmem_req.rw) begin
                    for (int l = 0; l < NUM_LANES; l++) begin
                        dmem[dmem_req.addr[l]] = dmem_req.data[l];
                    end
                end else begin
                    for (int l = 0; l < NUM_LANES; l++) begin
                        rd_rsp.data[l] = read_data(dmem_req.addr[l]);
                    end
                    rd_rsp.tag = dmem_req.tag;
                    drsp_q.push_back(rd_rsp);
                    drsp_due.push_back(cycle + rand_delay());
                end
                dcred_due.push_back(cycle + rand_delay());
            end
            // One response and one credit per port and cycle
            idx = first_due(irsp_due, cycle);
            if (idx >= 0) begin
                imem_rsp_valid <= 1'b1;
                imem_rsp       <= irsp_q[idx];
                irsp_q.delete(idx);
                irsp_due.delete(idx);
            end
            idx = first_due(drsp_due, cycle);
            if (idx >= 0) begin
                dmem_rsp_valid <= 1'b1;
                dmem_rsp       <= drsp_q[idx];
                drsp_q.delete(idx);
                drsp_due.delete(idx);
            end
            idx = first_due(icred_due, cycle);
            if (!hold_credits && idx >= 0) begin
                imem_credit <= 1'b1;
                icred_due.delete(idx);
            end
            idx = first_due(dcred_due, cycle);
            if (!hold_credits && idx >= 0) begin
                dmem_credit <= 1'b1;
                dcred_due.delete(idx);
            end
        end
    end

endmodule

`default_nettype wire
